// ==== common/mips_pkg.sv ====
package mips_pkg;

   // Datapath widths
   localparam int NB_REG        = 32;
   localparam int NB_INSTR      = 32;
   localparam int NB_REG_ADDR   = 5;
   localparam int REGFILE_DEPTH = 32;
   localparam int NB_INM        = 16;
   localparam int NB_SHAMT      = 5;

   // Instruction memory
   localparam int IMEM_DEPTH    = 256;
   localparam int NB_IMEM_ADDR  = 8;

   // Field positions in the instruction word
   localparam int NB_OPCODE     = 6;
   localparam int NB_FUNCT      = 6;
   localparam int MSB_OPCODE    = 31;
   localparam int MSB_RS        = 25;
   localparam int MSB_RT        = 20;
   localparam int MSB_RD        = 15;
   localparam int MSB_SHAMT     = 10;

   // Opcodes
   localparam logic [NB_OPCODE-1:0] OPC_RTYPE = 6'h00;
   localparam logic [NB_OPCODE-1:0] OPC_ADDIU = 6'h09;
   localparam logic [NB_OPCODE-1:0] OPC_ANDI  = 6'h0C;
   localparam logic [NB_OPCODE-1:0] OPC_ORI   = 6'h0D;
   localparam logic [NB_OPCODE-1:0] OPC_LUI   = 6'h0F;
   localparam logic [NB_OPCODE-1:0] OPC_HALT  = 6'h3F;

   // R-type function codes
   localparam logic [NB_FUNCT-1:0] FN_SLL  = 6'h00;
   localparam logic [NB_FUNCT-1:0] FN_ADDU = 6'h21;
   localparam logic [NB_FUNCT-1:0] FN_SUBU = 6'h23;
   localparam logic [NB_FUNCT-1:0] FN_AND  = 6'h24;
   localparam logic [NB_FUNCT-1:0] FN_OR   = 6'h25;
   localparam logic [NB_FUNCT-1:0] FN_XOR  = 6'h26;
   localparam logic [NB_FUNCT-1:0] FN_SLT  = 6'h2A;

   localparam int NB_ALU_OP = 4;

   // ALU operations, decode to execute
   typedef enum logic [NB_ALU_OP-1:0] {
      ALU_ADD = 4'd0,
      ALU_SUB = 4'd1,
      ALU_AND = 4'd2,
      ALU_OR  = 4'd3,
      ALU_XOR = 4'd4,
      ALU_SLT = 4'd5,
      ALU_SLL = 4'd6,
      ALU_LUI = 4'd7
   } alu_op_e;

endpackage

// ==== fetch/instruction_fetch.sv ====
`timescale 1ns/1ps

module instruction_fetch import mips_pkg::*; (
   input  logic                    i_clock,
   input  logic                    reset,
   input  logic                    i_run,
   input  logic                    i_halt_seen,
   input  logic                    i_prog_we,
   input  logic [NB_IMEM_ADDR-1:0] i_prog_addr,
   input  logic [NB_INSTR-1:0]     i_prog_data,
   output logic [NB_INSTR-1:0]     o_instr,
   output logic                    o_valid
);

   logic [NB_INSTR-1:0]     imem [IMEM_DEPTH];
   logic [NB_IMEM_ADDR-1:0] pc;
   logic                    issue;

   assign issue = i_run & ~i_halt_seen;

   // Program load, host side, only while stopped
   always_ff @(posedge i_clock) begin
      if (i_prog_we && !i_run) begin
         imem[i_prog_addr] <= i_prog_data;
      end
   end

   // Word-addressed PC
   always_ff @(posedge i_clock) begin
      if (reset) begin
         pc      <= '0;
         o_valid <= 1'b0;
      end else begin
         o_valid <= issue;
         if (issue) begin
            pc <= pc + 1'b1;
         end
      end
   end

   // Idle cycles push a nop into decode
   always_ff @(posedge i_clock) begin
      if (issue) begin
         o_instr <= imem[pc];
      end else begin
         o_instr <= '0;
      end
   end

   // Once decode has seen HALT the PC must stay frozen
   assert property (@(posedge i_clock) disable iff (reset)
      i_halt_seen |=> $stable(pc));

endmodule

// ==== decode/instruction_decode.sv ====
`timescale 1ns/1ps

module instruction_decode import mips_pkg::*; (
   input  logic                   i_clock,
   input  logic                   reset,
   input  logic [NB_INSTR-1:0]    i_instr,
   input  logic                   i_valid,
   input  logic                   i_wb_we,
   input  logic [NB_REG_ADDR-1:0] i_wb_rd,
   input  logic [NB_REG-1:0]      i_wb_data,
   input  logic [NB_REG_ADDR-1:0] i_debug_reg_addr,
   output logic [NB_REG-1:0]      o_a,
   output logic [NB_REG-1:0]      o_b,
   output logic [NB_REG-1:0]      o_inm,
   output logic [NB_SHAMT-1:0]    o_shamt,
   output alu_op_e                o_alu_op,
   output logic                   o_use_inm,
   output logic [NB_REG_ADDR-1:0] o_rd,
   output logic                   o_we,
   output logic [NB_REG_ADDR-1:0] o_rs,
   output logic [NB_REG_ADDR-1:0] o_rt,
   output logic                   o_halt,
   output logic                   o_halt_seen,
   output logic [NB_REG-1:0]      o_debug_reg_data
);

   logic [NB_REG-1:0]      regs [REGFILE_DEPTH];

   logic [NB_OPCODE-1:0]   opcode;
   logic [NB_FUNCT-1:0]    funct;
   logic [NB_REG_ADDR-1:0] rs;
   logic [NB_REG_ADDR-1:0] rt;
   logic [NB_REG_ADDR-1:0] rd;
   logic [NB_INM-1:0]      inm;
   logic [NB_REG-1:0]      rs_data;
   logic [NB_REG-1:0]      rt_data;

   logic                   dec_valid;
   logic                   halt_seen;
   alu_op_e                dec_alu_op;
   logic                   dec_use_inm;
   logic                   dec_we;
   logic                   dec_halt;
   logic [NB_REG_ADDR-1:0] dec_dest;
   logic [NB_REG-1:0]      dec_inm;

   assign opcode = i_instr[MSB_OPCODE -: NB_OPCODE];
   assign funct  = i_instr[NB_FUNCT-1:0];
   assign rs     = i_instr[MSB_RS -: NB_REG_ADDR];
   assign rt     = i_instr[MSB_RT -: NB_REG_ADDR];
   assign rd     = i_instr[MSB_RD -: NB_REG_ADDR];
   assign inm    = i_instr[NB_INM-1:0];

   // Anything fetched behind a HALT is dropped here
   assign dec_valid   = i_valid & ~halt_seen;
   assign o_halt_seen = halt_seen;

   // r0 is never written, so it stays at its reset value
   always_ff @(posedge i_clock) begin
      if (reset) begin
         for (int i = 0; i < REGFILE_DEPTH; i++) begin
            regs[i] <= '0;
         end
      end else if (i_wb_we && i_wb_rd != '0) begin
         regs[i_wb_rd] <= i_wb_data;
      end
   end

   // Write-through covers the instruction two ahead
   assign rs_data = (i_wb_we && i_wb_rd != '0 && i_wb_rd == rs) ? i_wb_data : regs[rs];
   assign rt_data = (i_wb_we && i_wb_rd != '0 && i_wb_rd == rt) ? i_wb_data : regs[rt];

   always_comb begin
      dec_alu_op  = ALU_ADD;
      dec_use_inm = 1'b0;
      dec_we      = 1'b0;
      dec_halt    = 1'b0;
      dec_dest    = rd;
      dec_inm     = {{(NB_REG-NB_INM){1'b0}}, inm};
      case (opcode)
         OPC_RTYPE: begin
            dec_we = 1'b1;
            case (funct)
               FN_SLL:  dec_alu_op = ALU_SLL;
               FN_ADDU: dec_alu_op = ALU_ADD;
               FN_SUBU: dec_alu_op = ALU_SUB;
               FN_AND:  dec_alu_op = ALU_AND;
               FN_OR:   dec_alu_op = ALU_OR;
               FN_XOR:  dec_alu_op = ALU_XOR;
               FN_SLT:  dec_alu_op = ALU_SLT;
               default: dec_we = 1'b0;
            endcase
         end
         OPC_ADDIU: begin
            dec_use_inm = 1'b1;
            dec_we      = 1'b1;
            dec_dest    = rt;
            dec_inm     = {{(NB_REG-NB_INM){inm[NB_INM-1]}}, inm};
         end
         OPC_ANDI: begin
            dec_alu_op  = ALU_AND;
            dec_use_inm = 1'b1;
            dec_we      = 1'b1;
            dec_dest    = rt;
         end
         OPC_ORI: begin
            dec_alu_op  = ALU_OR;
            dec_use_inm = 1'b1;
            dec_we      = 1'b1;
            dec_dest    = rt;
         end
         OPC_LUI: begin
            dec_alu_op  = ALU_LUI;
            dec_use_inm = 1'b1;
            dec_we      = 1'b1;
            dec_dest    = rt;
         end
         OPC_HALT: dec_halt = 1'b1;
         default: dec_we = 1'b0;
      endcase
      if (!dec_valid) begin
         dec_we   = 1'b0;
         dec_halt = 1'b0;
      end
   end

   always_ff @(posedge i_clock) begin
      if (reset) begin
         o_we      <= 1'b0;
         o_halt    <= 1'b0;
         halt_seen <= 1'b0;
      end else begin
         o_we   <= dec_we;
         o_halt <= dec_halt;
         if (dec_halt) begin
            halt_seen <= 1'b1;
         end
      end
   end

   always_ff @(posedge i_clock) begin
      o_a       <= rs_data;
      o_b       <= rt_data;
      o_inm     <= dec_inm;
      o_shamt   <= i_instr[MSB_SHAMT -: NB_SHAMT];
      o_alu_op  <= dec_alu_op;
      o_use_inm <= dec_use_inm;
      o_rd      <= dec_dest;
      o_rs      <= rs;
      o_rt      <= rt;
   end

   // Debug readout, one cycle
   always_ff @(posedge i_clock) begin
      o_debug_reg_data <= regs[i_debug_reg_addr];
   end

   // r0 holds zero however often writeback targets it
   assert property (@(posedge i_clock) disable iff (reset) regs[0] == '0);

endmodule

// ==== execution/forwarding_unit.sv ====
`timescale 1ns/1ps

module forwarding_unit import mips_pkg::*; (
   input  logic [NB_REG_ADDR-1:0] i_rs,
   input  logic [NB_REG_ADDR-1:0] i_rt,
   input  logic [NB_REG-1:0]      i_a,
   input  logic [NB_REG-1:0]      i_b,
   input  logic                   i_wb_we,
   input  logic [NB_REG_ADDR-1:0] i_wb_rd,
   input  logic [NB_REG-1:0]      i_wb_data,
   output logic [NB_REG-1:0]      o_fwd_a,
   output logic [NB_REG-1:0]      o_fwd_b
);

   logic wb_live;
   logic hit_a;
   logic hit_b;

   // Writes to r0 are never forwarded
   assign wb_live = i_wb_we && (i_wb_rd != '0);

   assign hit_a = wb_live && (i_wb_rd == i_rs);
   assign hit_b = wb_live && (i_wb_rd == i_rt);

   // Previous instruction's result, still in the writeback register
   assign o_fwd_a = hit_a ? i_wb_data : i_a;
   assign o_fwd_b = hit_b ? i_wb_data : i_b;

endmodule

// ==== execution/execution.sv ====
`timescale 1ns/1ps

module execution import mips_pkg::*; (
   input  logic                   i_clock,
   input  logic                   reset,
   input  logic [NB_REG-1:0]      i_a,
   input  logic [NB_REG-1:0]      i_b,
   input  logic [NB_REG-1:0]      i_inm,
   input  logic [NB_SHAMT-1:0]    i_shamt,
   input  alu_op_e                i_alu_op,
   input  logic                   i_use_inm,
   input  logic [NB_REG_ADDR-1:0] i_rd,
   input  logic                   i_we,
   input  logic                   i_halt,
   input  logic [NB_REG-1:0]      i_fwd_a,
   input  logic [NB_REG-1:0]      i_fwd_b,
   output logic                   o_wb_we,
   output logic [NB_REG_ADDR-1:0] o_wb_rd,
   output logic [NB_REG-1:0]      o_wb_data,
   output logic                   o_halted
);

   logic [NB_REG-1:0] b_sel;
   logic [NB_REG-1:0] alu_result;

   assign b_sel = i_use_inm ? i_inm : i_fwd_b;

   always_comb begin
      case (i_alu_op)
         ALU_ADD: alu_result = i_fwd_a + b_sel;
         ALU_SUB: alu_result = i_fwd_a - b_sel;
         ALU_AND: alu_result = i_fwd_a & b_sel;
         ALU_OR:  alu_result = i_fwd_a | b_sel;
         ALU_XOR: alu_result = i_fwd_a ^ b_sel;
         // Signed compare
         ALU_SLT: alu_result = {{(NB_REG-1){1'b0}}, $signed(i_fwd_a) < $signed(b_sel)};
         // Shifts rt, not rs
         ALU_SLL: alu_result = b_sel << i_shamt;
         ALU_LUI: alu_result = {b_sel[NB_INM-1:0], {(NB_REG-NB_INM){1'b0}}};
         default: alu_result = '0;
      endcase
   end

   // Halted sets when HALT reaches writeback and holds until reset
   always_ff @(posedge i_clock) begin
      if (reset) begin
         o_wb_we  <= 1'b0;
         o_halted <= 1'b0;
      end else begin
         o_wb_we  <= i_we;
         o_halted <= o_halted | i_halt;
      end
   end

   always_ff @(posedge i_clock) begin
      o_wb_rd   <= i_rd;
      o_wb_data <= alu_result;
   end

   assert property (@(posedge i_clock) disable iff (reset)
      i_we |-> !$isunknown(i_alu_op));

endmodule

// ==== source/mips_pipeline.sv ====
`timescale 1ns/1ps

module mips_pipeline import mips_pkg::*; (
   input  logic                    i_clock,
   input  logic                    reset,
   input  logic                    i_run,
   input  logic                    i_prog_we,
   input  logic [NB_IMEM_ADDR-1:0] i_prog_addr,
   input  logic [NB_INSTR-1:0]     i_prog_data,
   input  logic [NB_REG_ADDR-1:0]  i_debug_reg_addr,
   output logic                    o_halted,
   output logic [NB_REG-1:0]       o_debug_reg_data
);

   // Fetch to decode
   logic [NB_INSTR-1:0]    fe_instr;
   logic                   fe_valid;

   // Decode to fetch
   logic                   de_halt_seen;

   // Decode to execution
   logic [NB_REG-1:0]      de_a;
   logic [NB_REG-1:0]      de_b;
   logic [NB_REG-1:0]      de_inm;
   logic [NB_SHAMT-1:0]    de_shamt;
   alu_op_e                de_alu_op;
   logic                   de_use_inm;
   logic [NB_REG_ADDR-1:0] de_rd;
   logic                   de_we;
   logic [NB_REG_ADDR-1:0] de_rs;
   logic [NB_REG_ADDR-1:0] de_rt;
   logic                   de_halt;

   // Writeback stage, back to decode and forwarding
   logic                   wb_we;
   logic [NB_REG_ADDR-1:0] wb_rd;
   logic [NB_REG-1:0]      wb_data;

   logic [NB_REG-1:0]      fwd_a;
   logic [NB_REG-1:0]      fwd_b;

   instruction_fetch u_instruction_fetch (
      .i_clock     (i_clock),
      .reset       (reset),
      .i_run       (i_run),
      .i_halt_seen (de_halt_seen),
      .i_prog_we   (i_prog_we),
      .i_prog_addr (i_prog_addr),
      .i_prog_data (i_prog_data),
      .o_instr     (fe_instr),
      .o_valid     (fe_valid)
   );

   instruction_decode u_instruction_decode (
      .i_clock          (i_clock),
      .reset            (reset),
      .i_instr          (fe_instr),
      .i_valid          (fe_valid),
      .i_wb_we          (wb_we),
      .i_wb_rd          (wb_rd),
      .i_wb_data        (wb_data),
      .i_debug_reg_addr (i_debug_reg_addr),
      .o_a              (de_a),
      .o_b              (de_b),
      .o_inm            (de_inm),
      .o_shamt          (de_shamt),
      .o_alu_op         (de_alu_op),
      .o_use_inm        (de_use_inm),
      .o_rd             (de_rd),
      .o_we             (de_we),
      .o_rs             (de_rs),
      .o_rt             (de_rt),
      .o_halt           (de_halt),
      .o_halt_seen      (de_halt_seen),
      .o_debug_reg_data (o_debug_reg_data)
   );

   execution u_execution (
      .i_clock   (i_clock),
      .reset     (reset),
      .i_a       (de_a),
      .i_b       (de_b),
      .i_inm     (de_inm),
      .i_shamt   (de_shamt),
      .i_alu_op  (de_alu_op),
      .i_use_inm (de_use_inm),
      .i_rd      (de_rd),
      .i_we      (de_we),
      .i_halt    (de_halt),
      .i_fwd_a   (fwd_a),
      .i_fwd_b   (fwd_b),
      .o_wb_we   (wb_we),
      .o_wb_rd   (wb_rd),
      .o_wb_data (wb_data),
      .o_halted  (o_halted)
   );

   forwarding_unit u_forwarding_unit (
      .i_rs      (de_rs),
      .i_rt      (de_rt),
      .i_a       (de_a),
      .i_b       (de_b),
      .i_wb_we   (wb_we),
      .i_wb_rd   (wb_rd),
      .i_wb_data (wb_data),
      .o_fwd_a   (fwd_a),
      .o_fwd_b   (fwd_b)
   );

endmodule

// ==== sim/tb_program.svh ====
`ifndef TB_PROGRAM_SVH
`define TB_PROGRAM_SVH

// Ops 0 to 6 are ADDU SUBU AND OR XOR SLT SLL, 7 to 10 are ADDIU ANDI ORI LUI
localparam int NUM_OPS = 11;
localparam int OP_ORI  = 9;
localparam int OP_LUI  = 10;
localparam logic [NB_INSTR-1:0] HALT_WORD = {OPC_HALT, 26'd0};

logic [NB_INSTR-1:0] program_q [$];
logic [NB_REG-1:0]   model_regs [REGFILE_DEPTH];

function automatic int pick_op(input int limit);
   return int'(take_bits(4) % limit);
endfunction

// src is rs, except for SLL where it is rt
function automatic logic [NB_INSTR-1:0] encode(input int op,
                                               input logic [NB_REG_ADDR-1:0] dst,
                                               input logic [NB_REG_ADDR-1:0] src);
   logic [NB_REG_ADDR-1:0] other;
   logic [NB_SHAMT-1:0]    shamt;
   logic [NB_INM-1:0]      imm;
   other = NB_REG_ADDR'(take_bits(NB_REG_ADDR));
   shamt = NB_SHAMT'(take_bits(NB_SHAMT));
   imm   = NB_INM'(take_bits(NB_INM));
   case (op)
      0: return {OPC_RTYPE, src, other, dst, 5'd0, FN_ADDU};
      1: return {OPC_RTYPE, src, other, dst, 5'd0, FN_SUBU};
      2: return {OPC_RTYPE, src, other, dst, 5'd0, FN_AND};
      3: return {OPC_RTYPE, src, other, dst, 5'd0, FN_OR};
      4: return {OPC_RTYPE, src, other, dst, 5'd0, FN_XOR};
      5: return {OPC_RTYPE, src, other, dst, 5'd0, FN_SLT};
      6: return {OPC_RTYPE, 5'd0, src, dst, shamt, FN_SLL};
      7: return {OPC_ADDIU, src, dst, imm};
      8: return {OPC_ANDI, src, dst, imm};
      9: return {OPC_ORI, src, dst, imm};
      default: return {OPC_LUI, 5'd0, dst, imm};
   endcase
endfunction

function automatic void build_mix(input int count);
   int op;
   program_q.delete();
   for (int i = 0; i < count; i++) begin
      // Last eleven sweep every operation once
      op = (i >= count - NUM_OPS) ? i - (count - NUM_OPS) : pick_op(NUM_OPS);
      program_q.push_back(encode(op, NB_REG_ADDR'(take_bits(5)), NB_REG_ADDR'(take_bits(5))));
   end
   program_q.push_back(HALT_WORD);
endfunction

function automatic void build_chain(input int count);
   logic [NB_REG_ADDR-1:0] prev;
   logic [NB_REG_ADDR-1:0] dst;
   int                     op;
   program_q.delete();
   prev = NB_REG_ADDR'(take_bits(5));
   for (int i = 0; i < count; i++) begin
      dst = NB_REG_ADDR'(take_bits(4) + 1);
      // LUI reads no register, so it would break the chain
      op = (i == 0) ? OP_ORI : pick_op(OP_LUI);
      program_q.push_back(encode(op, dst, prev));
      prev = dst;
   end
   program_q.push_back(HALT_WORD);
endfunction

function automatic void build_r0_writes(input int pairs);
   program_q.delete();
   for (int i = 0; i < pairs; i++) begin
      program_q.push_back(encode(pick_op(NUM_OPS), '0, NB_REG_ADDR'(take_bits(5))));
      program_q.push_back(encode(pick_op(OP_LUI), NB_REG_ADDR'(take_bits(4) + 1), '0));
   end
   program_q.push_back(HALT_WORD);
endfunction

// Everything after the HALT writes a value of its own into r1 to r10
function automatic void build_halt_boundary();
   build_mix(20);
   for (int k = 0; k < 10; k++) begin
      program_q.push_back({OPC_ORI, 5'd0, NB_REG_ADDR'(k + 1), NB_INM'(16'hc000 + k)});
   end
endfunction

function automatic void run_model();
   logic [NB_INSTR-1:0]    instr;
   logic [NB_OPCODE-1:0]   opcode;
   logic [NB_FUNCT-1:0]    funct;
   logic [NB_REG_ADDR-1:0] dest;
   logic [NB_INM-1:0]      imm;
   logic [NB_REG-1:0]      a;
   logic [NB_REG-1:0]      b;
   logic [NB_REG-1:0]      result;
   logic                   write;
   foreach (model_regs[i]) begin
      model_regs[i] = '0;
   end
   for (int pc = 0; pc < program_q.size(); pc++) begin
      instr  = program_q[pc];
      opcode = instr[MSB_OPCODE -: NB_OPCODE];
      funct  = instr[NB_FUNCT-1:0];
      imm    = instr[NB_INM-1:0];
      a      = model_regs[instr[MSB_RS -: NB_REG_ADDR]];
      b      = model_regs[instr[MSB_RT -: NB_REG_ADDR]];
      dest   = instr[MSB_RT -: NB_REG_ADDR];
      result = '0;
      write  = 1'b1;
      if (opcode == OPC_HALT) begin
         break;
      end
      case (opcode)
         OPC_RTYPE: begin
            dest = instr[MSB_RD -: NB_REG_ADDR];
            case (funct)
               FN_ADDU: result = a + b;
               FN_SUBU: result = a - b;
               FN_AND:  result = a & b;
               FN_OR:   result = a | b;
               FN_XOR:  result = a ^ b;
               FN_SLT:  result = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
               FN_SLL:  result = b << instr[MSB_SHAMT -: NB_SHAMT];
               default: write = 1'b0;
            endcase
         end
         OPC_ADDIU: result = a + {{16{imm[15]}}, imm};
         OPC_ANDI:  result = a & {16'h0000, imm};
         OPC_ORI:   result = a | {16'h0000, imm};
         OPC_LUI:   result = {imm, 16'h0000};
         default:   write = 1'b0;
      endcase
      if (write && dest != '0) begin
         model_regs[dest] = result;
      end
   end
endfunction

`endif

// ==== sim/mips_pipeline_tb.sv ====
`timescale 1ns/1ps

module mips_pipeline_tb import mips_pkg::*; ();

   localparam int CLK_PERIOD   = 4;
   localparam int RESET_CYCLES = 16;
   localparam int NUM_TESTS    = 6;
   localparam int MAX_PROG_LEN = 65;
   // Loading and running each cost about one cycle per word
   localparam int TEST_CYCLES  = 2 * MAX_PROG_LEN + 60;
   localparam int WATCHDOG_NS  = NUM_TESTS * TEST_CYCLES * CLK_PERIOD;
   localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;

   logic                    i_clock;
   logic                    reset;
   logic                    i_run;
   logic                    i_prog_we;
   logic [NB_IMEM_ADDR-1:0] i_prog_addr;
   logic [NB_INSTR-1:0]     i_prog_data;
   logic [NB_REG_ADDR-1:0]  i_debug_reg_addr;
   logic                    o_halted;
   logic [NB_REG-1:0]       o_debug_reg_data;

   logic [31:0] lfsr_state;
   int          error_count;
   int          check_count;
   int          tests_run;
   int          tests_failed;

   mips_pipeline u_mips_pipeline (
      .i_clock          (i_clock),
      .reset            (reset),
      .i_run            (i_run),
      .i_prog_we        (i_prog_we),
      .i_prog_addr      (i_prog_addr),
      .i_prog_data      (i_prog_data),
      .i_debug_reg_addr (i_debug_reg_addr),
      .o_halted         (o_halted),
      .o_debug_reg_data (o_debug_reg_data)
   );

   initial begin
      i_clock = 1'b0;
      forever #(CLK_PERIOD / 2) i_clock = ~i_clock;
   end

   // Galois LFSR, one step per bit taken
   function automatic logic [31:0] take_bits(input int count);
      logic [31:0] bits;
      bits = '0;
      for (int i = 0; i < count; i++) begin
         bits = {bits[30:0], lfsr_state[0]};
         lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ LFSR_TAPS) : (lfsr_state >> 1);
      end
      return bits;
   endfunction

   `include "tb_program.svh"

   task automatic check_value(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
      check_count++;
      if (actual !== expected) begin
         error_count++;
         $display("[FAIL] %s: expected %h, actual %h", name, expected, actual);
      end
   endtask

   task automatic apply_reset();
      @(posedge i_clock);
      reset     <= 1'b1;
      i_run     <= 1'b0;
      i_prog_we <= 1'b0;
      repeat (RESET_CYCLES) @(posedge i_clock);
      reset <= 1'b0;
   endtask

   task automatic load_program();
      foreach (program_q[i]) begin
         @(posedge i_clock);
         i_prog_we   <= 1'b1;
         i_prog_addr <= NB_IMEM_ADDR'(i);
         i_prog_data <= program_q[i];
      end
      @(posedge i_clock);
      i_prog_we <= 1'b0;
   endtask

   task automatic start_and_wait(input string name, input int limit);
      int cycles;
      cycles = 0;
      @(posedge i_clock);
      i_run <= 1'b1;
      while (o_halted !== 1'b1 && cycles < limit) begin
         @(negedge i_clock);
         cycles++;
      end
      if (o_halted !== 1'b1) begin
         error_count++;
         $display("%s: o_halted did not rise within %0d cycles", name, limit);
      end
      @(posedge i_clock);
      i_run <= 1'b0;
   endtask

   // Readout is pipelined, data for the previous address shows each cycle
   task automatic read_and_compare(input string name);
      for (int r = 0; r <= REGFILE_DEPTH; r++) begin
         @(posedge i_clock);
         if (r < REGFILE_DEPTH) begin
            i_debug_reg_addr <= NB_REG_ADDR'(r);
         end
         @(negedge i_clock);
         if (r > 0) begin
            check_value($sformatf("%s r%0d", name, r - 1), model_regs[r - 1], o_debug_reg_data);
         end
      end
   endtask

   task automatic report_test(input string name, input int errors_before);
      int new_errors;
      new_errors = error_count - errors_before;
      tests_run++;
      if (new_errors == 0) begin
         $display("%-18s passed", name);
      end else begin
         tests_failed++;
         $display("%-18s failed with %0d errors", name, new_errors);
      end
   endtask

   task automatic run_case(input string name);
      int errors_before;
      errors_before = error_count;
      apply_reset();
      load_program();
      run_model();
      start_and_wait(name, 2 * program_q.size() + 20);
      read_and_compare(name);
      report_test(name, errors_before);
   endtask

   task automatic check_reset_state();
      int errors_before;
      errors_before = error_count;
      apply_reset();
      program_q.delete();
      run_model();
      @(negedge i_clock);
      check_value("reset_state o_halted", '0, NB_REG'(o_halted));
      read_and_compare("reset_state");
      report_test("reset_state", errors_before);
   endtask

   initial begin
      reset            = 1'b1;
      i_run            = 1'b0;
      i_prog_we        = 1'b0;
      i_prog_addr      = '0;
      i_prog_data      = '0;
      i_debug_reg_addr = '0;
      lfsr_state       = 32'h7e4a;
      error_count      = 0;
      check_count      = 0;
      tests_run        = 0;
      tests_failed     = 0;

      check_reset_state();
      build_chain(40);
      run_case("dep_chain");
      build_mix(64);
      run_case("random_mix");
      build_r0_writes(24);
      run_case("r0_writes");
      build_halt_boundary();
      run_case("halt_boundary");
      build_mix(32);
      run_case("rerun_after_reset");

      $display("Tests run %0d, failed %0d; checks %0d, errors %0d",
               tests_run, tests_failed, check_count, error_count);
      if (error_count == 0) begin
         $display("Simulation completed successfully");
      end else begin
         $display("Simulation failed");
      end
      $finish;
   end

   initial begin
      #(WATCHDOG_NS);
      $display("Watchdog expired after %0d ns, the run timed out", WATCHDOG_NS);
      $display("Simulation failed");
      $finish;
   end

endmodule

// ==== sim.f ====
+incdir+sim
common/mips_pkg.sv
fetch/instruction_fetch.sv
decode/instruction_decode.sv
execution/forwarding_unit.sv
execution/execution.sv
source/mips_pipeline.sv
sim/mips_pipeline_tb.sv

// ==== Bender.yml ====
package:
  name: mips_pipeline

sources:
  - common/mips_pkg.sv
  - fetch/instruction_fetch.sv
  - decode/instruction_decode.sv
  - execution/forwarding_unit.sv
  - execution/execution.sv
  - source/mips_pipeline.sv
  - target: simulation
    include_dirs:
      - sim
    files:
      - sim/mips_pipeline_tb.sv
